//--- common/board_cfg.svh
`ifndef BOARD_CFG_SVH
`define BOARD_CFG_SVH

// data memory depth in 32-bit words
`define MEM_WORDS 4096

// I/O window in byte addresses, both ends inclusive
`define IO_START 32'h0000_8000
`define IO_END   32'h0000_81FF

`endif

//--- common/board_pkg.sv
`default_nettype none

package board_pkg;

    typedef logic [31:0] word_t;        // one data word
    typedef logic [31:0] addr_t;        // byte address
    typedef logic [15:0] gpio_t;        // one bit per digital pin
    typedef logic [4:0]  irq_vector_t;  // 0 to 15 for inputs, 16 for the timer

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } store_width_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT_STORE   // a store lost to a load and is replayed this cycle
    } arb_state_t;

    typedef struct packed {
        logic         request;
        addr_t        address;
        word_t        data;
        store_width_t width;
    } store_req_t;

    typedef struct packed {
        logic  request;
        addr_t address;
    } load_req_t;

endpackage : board_pkg

`default_nettype wire

//--- hdl/mmio_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module mmio_arbiter (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  board_pkg::store_req_t  store_req_i,
    input  board_pkg::load_req_t   load_req_i,
    output logic                   store_done_o,
    output logic                   load_valid_o,
    output board_pkg::word_t       load_data_o,
    output board_pkg::store_req_t  mem_store_o,
    output board_pkg::load_req_t   mem_load_o,
    input  wire logic              mem_store_done_i,
    input  wire logic              mem_load_valid_i,
    input  board_pkg::word_t       mem_load_data_i,
    output board_pkg::gpio_t       gpo_write_o,
    output logic                   gpo_data_o,
    input  board_pkg::gpio_t       gpi_level_i,
    input  board_pkg::gpio_t       gpo_level_i,
    output logic                   timer_write_o,
    output logic [1:0]             timer_wr_index_o,
    output board_pkg::word_t       timer_wr_data_o,
    output logic [1:0]             timer_rd_index_o,
    input  board_pkg::word_t       timer_rd_data_i
);
    import board_pkg::*;

    arb_state_t state_q, state_d;
    store_req_t store_hold_q;   // store parked while a load takes the cycle
    store_req_t eff_store;      // the store acted on this cycle
    logic       store_in_io, store_io;
    logic       load_in_io, load_io;
    logic       io_done_q, io_valid_q;
    word_t      io_rd_data, io_rd_data_q;

    always_comb begin
        state_d   = ARB_IDLE;
        eff_store = store_req_i;
        unique case (state_q)
            ARB_IDLE: begin
                if (store_req_i.request && load_req_i.request) begin
                    state_d           = ARB_WAIT_STORE;
                    eff_store.request = 1'b0;  // load wins, store waits one cycle
                end
            end
            ARB_WAIT_STORE: begin
                eff_store         = store_hold_q;
                eff_store.request = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ARB_IDLE;
            io_done_q  <= 1'b0;
            io_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            io_done_q  <= store_io;
            io_valid_q <= load_io;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ARB_IDLE && store_req_i.request && load_req_i.request) begin
            store_hold_q <= store_req_i;
        end
        if (load_io) begin
            io_rd_data_q <= io_rd_data;  // captured at the request
        end
    end

    assign store_in_io = (eff_store.address >= `IO_START) && (eff_store.address <= `IO_END);
    assign store_io    = eff_store.request && store_in_io;

    always_comb begin
        mem_store_o         = eff_store;
        mem_store_o.request = eff_store.request && !store_in_io;
    end

    // bit 8 picks the timer, otherwise bit 7 clear picks an output pin
    always_comb begin
        gpo_write_o = '0;
        if (store_io && !eff_store.address[8] && !eff_store.address[7]) begin
            gpo_write_o[eff_store.address[5:2]] = 1'b1;
        end
    end

    assign gpo_data_o       = eff_store.data[0];
    assign timer_write_o    = store_io && eff_store.address[8];
    assign timer_wr_index_o = eff_store.address[3:2];
    assign timer_wr_data_o  = eff_store.data;

    assign load_in_io = (load_req_i.address >= `IO_START) && (load_req_i.address <= `IO_END);
    assign load_io    = load_req_i.request && load_in_io;

    assign mem_load_o.request = load_req_i.request && !load_in_io;
    assign mem_load_o.address = load_req_i.address;
    assign timer_rd_index_o   = load_req_i.address[3:2];

    always_comb begin
        io_rd_data = '0;  // pin reads are zero-extended
        if (load_req_i.address[8]) begin
            io_rd_data = timer_rd_data_i;
        end else if (load_req_i.address[7]) begin
            io_rd_data[0] = gpi_level_i[load_req_i.address[5:2]];
        end else begin
            io_rd_data[0] = gpo_level_i[load_req_i.address[5:2]];
        end
    end

    assign store_done_o = mem_store_done_i | io_done_q;
    assign load_valid_o = mem_load_valid_i | io_valid_q;
    assign load_data_o  = io_valid_q ? io_rd_data_q : mem_load_data_i;

    // a done is the answer to a store seen one cycle back, or two when deferred
    a_done_has_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_done_o |-> ($past(store_req_i.request) || $past(store_req_i.request, 2)));

    a_no_store_while_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == ARB_WAIT_STORE) |-> !store_req_i.request);

endmodule : mmio_arbiter

`default_nettype wire

//--- hdl/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module data_memory (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  board_pkg::store_req_t  store_req_i,
    input  board_pkg::load_req_t   load_req_i,
    output logic                   store_done_o,
    output logic                   load_valid_o,
    output board_pkg::word_t       load_data_o
);
    import board_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    word_t            mem [`MEM_WORDS];
    logic [IDX_W-1:0] store_idx, load_idx;
    logic [3:0]       byte_en;
    word_t            store_lanes;  // store data copied into every lane it may hit
    logic             store_done_q, load_valid_q;
    word_t            load_data_q;

    assign store_idx = store_req_i.address[IDX_W+1:2];
    assign load_idx  = load_req_i.address[IDX_W+1:2];

    always_comb begin
        unique case (store_req_i.width)
            BYTE: begin
                byte_en     = 4'b0001 << store_req_i.address[1:0];
                store_lanes = {4{store_req_i.data[7:0]}};
            end
            HALF: begin
                byte_en     = store_req_i.address[1] ? 4'b1100 : 4'b0011;
                store_lanes = {2{store_req_i.data[15:0]}};
            end
            default: begin
                byte_en     = 4'b1111;
                store_lanes = store_req_i.data;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (store_req_i.request) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[store_idx][i*8 +: 8] <= store_lanes[i*8 +: 8];
                end
            end
        end
        if (load_req_i.request) begin
            load_data_q <= mem[load_idx];  // old word when a store hits the same edge
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            store_done_q <= 1'b0;
            load_valid_q <= 1'b0;
        end else begin
            store_done_q <= store_req_i.request;
            load_valid_q <= load_req_i.request;
        end
    end

    assign store_done_o = store_done_q;
    assign load_valid_o = load_valid_q;
    assign load_data_o  = load_data_q;

    a_store_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_req_i.request |-> (store_req_i.address[31:2] < `MEM_WORDS));

    a_load_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_req_i.request |-> (load_req_i.address[31:2] < `MEM_WORDS));

endmodule : data_memory

`default_nettype wire

//--- gpio/gpio_ports.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_ports (
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  board_pkg::gpio_t  digital_i,
    output board_pkg::gpio_t  gpi_level_o,
    output board_pkg::gpio_t  gpi_rise_o,
    input  board_pkg::gpio_t  gpo_write_i,
    input  wire logic         gpo_data_i,
    output board_pkg::gpio_t  gpo_level_o
);
    import board_pkg::*;

    gpio_t sync1_q;  // first stage, may go metastable
    gpio_t sync2_q;
    gpio_t prev_q;   // level one cycle ago, for the rise
    gpio_t gpo_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= digital_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign gpi_level_o = sync2_q;
    assign gpi_rise_o  = sync2_q & ~prev_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpo_q <= '0;
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (gpo_write_i[i]) begin
                    gpo_q[i] <= gpo_data_i;
                end
            end
        end
    end

    assign gpo_level_o = gpo_q;

    a_gpo_write_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gpo_write_i));

endmodule : gpio_ports

`default_nettype wire

//--- timer/mmio_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_timer (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire logic          write_i,
    input  wire logic [1:0]    wr_index_i,
    input  board_pkg::word_t   wr_data_i,
    input  wire logic [1:0]    rd_index_i,
    output board_pkg::word_t   rd_data_o,
    output logic               timer_irq_o
);

    logic [63:0] counter_q;
    logic [63:0] compare_q;
    logic        counter_wr;  // a store to either counter word

    assign counter_wr = write_i && !wr_index_i[1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counter_q <= '0;
        end else if (counter_wr) begin
            if (wr_index_i[0]) begin
                counter_q[63:32] <= wr_data_i;
            end else begin
                counter_q[31:0] <= wr_data_i;
            end
        end else begin
            counter_q <= counter_q + 64'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            compare_q <= '0;
        end else if (write_i && wr_index_i[1]) begin
            if (wr_index_i[0]) begin
                compare_q[63:32] <= wr_data_i;
            end else begin
                compare_q[31:0] <= wr_data_i;
            end
        end
    end

    always_comb begin
        unique case (rd_index_i)
            2'd0:    rd_data_o = counter_q[31:0];
            2'd1:    rd_data_o = counter_q[63:32];
            2'd2:    rd_data_o = compare_q[31:0];
            default: rd_data_o = compare_q[63:32];
        endcase
    end

    // a zero compare means disarmed
    assign timer_irq_o = (compare_q != '0) && (counter_q >= compare_q);

endmodule : mmio_timer

`default_nettype wire

//--- hdl/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  board_pkg::gpio_t       gpi_rise_i,
    input  wire logic              timer_irq_i,
    input  wire logic              irq_ack_i,
    output logic                   irq_o,
    output board_pkg::irq_vector_t irq_vector_o
);
    import board_pkg::*;

    logic        timer_prev_q;
    logic        timer_rise;
    logic [16:0] pending_q;  // bit 16 is the timer, 15:0 the input pins

    assign timer_rise = timer_irq_i && !timer_prev_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            timer_prev_q <= 1'b0;
            pending_q    <= '0;
        end else begin
            timer_prev_q <= timer_irq_i;
            if (irq_ack_i) begin
                pending_q <= '0;  // edges in the acknowledge cycle are dropped
            end else begin
                pending_q <= pending_q | {timer_rise, gpi_rise_i};
            end
        end
    end

    assign irq_o = |pending_q;

    // timer first, then the highest input index
    always_comb begin
        irq_vector_o = '0;
        if (pending_q[16]) begin
            irq_vector_o = irq_vector_t'(16);
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (pending_q[i]) begin
                    irq_vector_o = irq_vector_t'(i);
                end
            end
        end
    end

endmodule : interrupt_controller

`default_nettype wire

//--- hdl/io_board.sv
`timescale 1ns/1ps
`default_nettype none

module io_board (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  board_pkg::store_req_t      store_req_i,
    input  board_pkg::load_req_t       load_req_i,
    output logic                       store_done_o,
    output logic                       load_valid_o,
    output board_pkg::word_t           load_data_o,
    input  wire logic                  irq_ack_i,
    output logic                       irq_o,
    output board_pkg::irq_vector_t     irq_vector_o,
    input  board_pkg::gpio_t           digital_i,
    output board_pkg::gpio_t           digital_o
);
    import board_pkg::*;

    logic rst_meta_q;
    logic rst_sync_n;  // internal reset, released two edges after rst_n_i rises

    store_req_t mem_store;
    load_req_t  mem_load;
    logic       mem_store_done;
    logic       mem_load_valid;
    word_t      mem_load_data;

    gpio_t gpo_write;
    logic  gpo_data;
    gpio_t gpi_level;
    gpio_t gpi_rise;
    gpio_t gpo_level;

    logic       timer_write;
    logic [1:0] timer_wr_index;
    word_t      timer_wr_data;
    logic [1:0] timer_rd_index;
    word_t      timer_rd_data;
    logic       timer_irq;

    // assert asynchronously, release synchronously
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_meta_q <= 1'b0;
            rst_sync_n <= 1'b0;
        end else begin
            rst_meta_q <= 1'b1;
            rst_sync_n <= rst_meta_q;
        end
    end

    mmio_arbiter i_arbiter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_sync_n),
        .store_req_i      (store_req_i),
        .load_req_i       (load_req_i),
        .store_done_o     (store_done_o),
        .load_valid_o     (load_valid_o),
        .load_data_o      (load_data_o),
        .mem_store_o      (mem_store),
        .mem_load_o       (mem_load),
        .mem_store_done_i (mem_store_done),
        .mem_load_valid_i (mem_load_valid),
        .mem_load_data_i  (mem_load_data),
        .gpo_write_o      (gpo_write),
        .gpo_data_o       (gpo_data),
        .gpi_level_i      (gpi_level),
        .gpo_level_i      (gpo_level),
        .timer_write_o    (timer_write),
        .timer_wr_index_o (timer_wr_index),
        .timer_wr_data_o  (timer_wr_data),
        .timer_rd_index_o (timer_rd_index),
        .timer_rd_data_i  (timer_rd_data)
    );

    data_memory i_memory (
        .clk_i        (clk_i),
        .rst_n_i      (rst_sync_n),
        .store_req_i  (mem_store),
        .load_req_i   (mem_load),
        .store_done_o (mem_store_done),
        .load_valid_o (mem_load_valid),
        .load_data_o  (mem_load_data)
    );

    gpio_ports i_gpio (
        .clk_i       (clk_i),
        .rst_n_i     (rst_sync_n),
        .digital_i   (digital_i),
        .gpi_level_o (gpi_level),
        .gpi_rise_o  (gpi_rise),
        .gpo_write_i (gpo_write),
        .gpo_data_i  (gpo_data),
        .gpo_level_o (gpo_level)
    );

    assign digital_o = gpo_level;

    mmio_timer i_timer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_sync_n),
        .write_i     (timer_write),
        .wr_index_i  (timer_wr_index),
        .wr_data_i   (timer_wr_data),
        .rd_index_i  (timer_rd_index),
        .rd_data_o   (timer_rd_data),
        .timer_irq_o (timer_irq)
    );

    interrupt_controller i_irq_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_sync_n),
        .gpi_rise_i   (gpi_rise),
        .timer_irq_i  (timer_irq),
        .irq_ack_i    (irq_ack_i),
        .irq_o        (irq_o),
        .irq_vector_o (irq_vector_o)
    );

endmodule : io_board

`default_nettype wire

//--- verif/io_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_cfg.svh"

module io_board_tb;
    import board_pkg::*;

    localparam word_t NO_IRQ   = 32'hFFFF_FFFF;           // pin entry where no bit rises
    localparam addr_t GPO_BASE = `IO_START;
    localparam addr_t GPI_BASE = `IO_START + 32'h80;
    localparam addr_t TMR_BASE = `IO_START + 32'h100;

    typedef enum logic [2:0] {
        OP_STORE,
        OP_LOAD,
        OP_STORE_LOAD,
        OP_SET_PINS,
        OP_ACK,
        OP_TIMER
    } op_t;

    typedef struct packed {
        op_t          op;
        addr_t        addr;
        word_t        data;      // store data, or the compare distance of a timer entry
        store_width_t width;
        gpio_t        pins;
        word_t        expected;
    } entry_t;

    logic        clk_i;
    logic        rst_n_i;
    store_req_t  store_req;
    load_req_t   load_req;
    logic        store_done;
    logic        load_valid;
    word_t       load_data;
    logic        irq_ack;
    logic        irq;
    irq_vector_t irq_vector;
    gpio_t       digital_in;
    gpio_t       digital_out;

    entry_t table_q[$];
    word_t  mem_model[int];   // word index to expected contents
    gpio_t  gpo_model;
    gpio_t  pin_model;
    integer seed;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    io_board i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .store_req_i  (store_req),
        .load_req_i   (load_req),
        .store_done_o (store_done),
        .load_valid_o (load_valid),
        .load_data_o  (load_data),
        .irq_ack_i    (irq_ack),
        .irq_o        (irq),
        .irq_vector_o (irq_vector),
        .digital_i    (digital_in),
        .digital_o    (digital_out)
    );

    always #2 clk_i = ~clk_i;  // 4 ns period

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic in_io(addr_t addr);
        return (addr >= `IO_START) && (addr <= `IO_END);
    endfunction

    function automatic word_t apply_store(word_t old, addr_t addr, word_t data,
                                          store_width_t width);
        word_t merged;
        merged = old;
        case (width)
            BYTE:    merged[{addr[1:0], 3'b000} +: 8] = data[7:0];
            HALF:    merged[{addr[1], 4'b0000} +: 16] = data[15:0];
            default: merged = data;
        endcase
        return merged;
    endfunction

    function automatic word_t highest_rise(gpio_t rose);
        for (int i = 15; i >= 0; i--) begin
            if (rose[i]) begin
                return word_t'(i);
            end
        end
        return NO_IRQ;
    endfunction

    function automatic word_t mem_word(addr_t addr);
        if (mem_model.exists(int'(addr[31:2]))) begin
            return mem_model[int'(addr[31:2])];
        end
        return '0;
    endfunction

    function automatic word_t io_model(addr_t addr);
        if (addr[8]) begin
            return '0;  // compare words are only read here while still at reset value
        end
        if (addr[7]) begin
            return word_t'(pin_model[addr[5:2]]);
        end
        return word_t'(gpo_model[addr[5:2]]);
    endfunction

    function automatic void push_entry(op_t op, addr_t addr, word_t data, store_width_t width,
                                       gpio_t pins, word_t expected);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.width    = width;
        e.pins     = pins;
        e.expected = expected;
        table_q.push_back(e);
    endfunction

    // a store entry expects digital_o as it stands after the store
    function automatic void add_store(addr_t addr, word_t data, store_width_t width);
        if (in_io(addr)) begin
            gpo_model[addr[5:2]] = data[0];
        end else begin
            mem_model[int'(addr[31:2])] = apply_store(mem_word(addr), addr, data, width);
        end
        push_entry(OP_STORE, addr, data, width, '0, word_t'(gpo_model));
    endfunction

    function automatic void add_load(addr_t addr);
        push_entry(OP_LOAD, addr, '0, WORD, '0, in_io(addr) ? io_model(addr) : mem_word(addr));
    endfunction

    function automatic void add_store_load(addr_t addr, word_t data, store_width_t width);
        word_t old;
        old = mem_word(addr);
        mem_model[int'(addr[31:2])] = apply_store(old, addr, data, width);
        push_entry(OP_STORE_LOAD, addr, data, width, '0, old);  // the load sees the old word
    endfunction

    function automatic void add_pins(gpio_t pins);
        gpio_t rose;
        rose      = pins & ~pin_model;
        pin_model = pins;
        push_entry(OP_SET_PINS, '0, '0, WORD, pins, highest_rise(rose));
    endfunction

    function automatic void build_table();
        addr_t base;
        add_load(TMR_BASE + 32'h08);
        add_load(TMR_BASE + 32'h0C);
        add_load(GPO_BASE + 32'h1C);
        for (int k = 0; k < 3; k++) begin
            base = addr_t'($unsigned($random(seed)) % `MEM_WORDS) << 2;
            add_store(base, $random(seed), WORD);
            add_load(base);
            add_store(base + addr_t'((k % 2) * 2), $random(seed), HALF);
            add_load(base);
            add_store(base + addr_t'(k), $random(seed), BYTE);
            add_load(base);
        end
        base = addr_t'($unsigned($random(seed)) % `MEM_WORDS) << 2;
        add_store(base, $random(seed), WORD);
        add_store_load(base, $random(seed), WORD);
        add_load(base);
        add_store_load(base + 32'd3, $random(seed), BYTE);
        add_load(base);
        add_store(GPO_BASE + 32'h14, 32'h0000_0003, WORD);  // pin 5 takes bit 0 of the data
        add_load(GPO_BASE + 32'h14);
        add_load(GPO_BASE + 32'h10);
        add_store(GPO_BASE + 32'h30, 32'h0000_0001, WORD);
        add_store(GPO_BASE + 32'h14, 32'hFFFF_FFFE, WORD);
        add_load(GPO_BASE + 32'h14);
        add_load(GPO_BASE + 32'h30);
        add_pins(16'h0024);
        add_load(GPI_BASE + 32'h14);
        add_load(GPI_BASE + 32'h0C);
        push_entry(OP_ACK, '0, '0, WORD, '0, '0);
        add_pins(16'h8024);
        push_entry(OP_ACK, '0, '0, WORD, '0, '0);
        add_pins(16'h0000);
        add_load(GPI_BASE + 32'h3C);
        add_pins(gpio_t'($random(seed)));
        push_entry(OP_ACK, '0, '0, WORD, '0, '0);
        add_load(GPI_BASE + 32'h28);
        push_entry(OP_TIMER, '0, 32'd40, WORD, '0, 32'd16);
        push_entry(OP_ACK, '0, '0, WORD, '0, '0);
        add_pins(16'h0000);
        add_pins(16'h0101);
        push_entry(OP_TIMER, '0, 32'd30, WORD, '0, 32'd16);  // timer beats the pending pins
        push_entry(OP_ACK, '0, '0, WORD, '0, '0);
    endfunction

    // latency counts falling edges from the request until done is seen
    task automatic send_store(input addr_t addr, input word_t data, input store_width_t width,
                              output int latency);
        @(negedge clk_i);
        store_req.request = 1'b1;
        store_req.address = addr;
        store_req.data    = data;
        store_req.width   = width;
        @(negedge clk_i);
        store_req.request = 1'b0;
        latency = 1;
        while (!store_done && latency < 6) begin
            @(negedge clk_i);
            latency++;
        end
    endtask

    task automatic send_load(input addr_t addr, output word_t data, output logic valid);
        @(negedge clk_i);
        load_req.request = 1'b1;
        load_req.address = addr;
        @(negedge clk_i);
        load_req.request = 1'b0;
        valid = load_valid;
        data  = load_data;
    endtask

    task automatic run_entry(input entry_t e, input int index);
        op_t   op;
        string name;
        int    latency;
        int    start;
        word_t data;
        logic  valid;
        word_t count0;
        op   = e.op;
        name = $sformatf("entry %0d %s", index, op.name());
        case (op)
            OP_STORE: begin
                send_store(e.addr, e.data, e.width, latency);
                check_value({name, " done latency"}, 1, latency);
                check_value({name, " digital_o"}, e.expected, word_t'(digital_out));
            end
            OP_LOAD: begin
                send_load(e.addr, data, valid);
                check_value({name, " load valid"}, 1, word_t'(valid));
                check_value({name, " load data"}, e.expected, data);
            end
            OP_STORE_LOAD: begin
                @(negedge clk_i);
                store_req.request = 1'b1;
                store_req.address = e.addr;
                store_req.data    = e.data;
                store_req.width   = e.width;
                load_req.request  = 1'b1;
                load_req.address  = e.addr;
                @(negedge clk_i);
                store_req.request = 1'b0;
                load_req.request  = 1'b0;
                check_value({name, " load valid"}, 1, word_t'(load_valid));
                check_value({name, " old data"}, e.expected, load_data);
                check_value({name, " done held back"}, 0, word_t'(store_done));
                @(negedge clk_i);
                check_value({name, " deferred done"}, 1, word_t'(store_done));
                check_value({name, " valid pulse"}, 0, word_t'(load_valid));
            end
            OP_SET_PINS: begin
                @(negedge clk_i);
                digital_in = e.pins;
                if (e.expected == NO_IRQ) begin
                    repeat (4) @(negedge clk_i);  // two sync stages, then the rise cycle
                end else begin
                    latency = 0;
                    while (!irq && latency < 8) begin
                        @(negedge clk_i);
                        latency++;
                    end
                    check_value({name, " irq"}, 1, word_t'(irq));
                    check_value({name, " vector"}, e.expected, word_t'(irq_vector));
                end
            end
            OP_ACK: begin
                @(negedge clk_i);
                irq_ack = 1'b1;
                @(negedge clk_i);
                irq_ack = 1'b0;
                check_value({name, " irq cleared"}, 0, word_t'(irq));
            end
            OP_TIMER: begin
                send_load(TMR_BASE, count0, valid);
                start = cycle_count - 1;  // rising edges counted from the counter sample
                check_value({name, " counter valid"}, 1, word_t'(valid));
                send_store(TMR_BASE + 32'h0C, '0, WORD, latency);
                check_value({name, " compare high done"}, 1, latency);
                send_store(TMR_BASE + 32'h08, count0 + e.data, WORD, latency);
                check_value({name, " compare low done"}, 1, latency);
                while (irq_vector != 5'd16 && cycle_count - start < int'(e.data) + 20) begin
                    @(negedge clk_i);
                end
                check_value({name, " irq"}, 1, word_t'(irq));
                check_value({name, " vector"}, e.expected, word_t'(irq_vector));
                check_value({name, " not early"}, 1,
                            word_t'(cycle_count - start >= int'(e.data)));
                send_load(TMR_BASE + 32'h08, data, valid);
                check_value({name, " compare readback"}, count0 + e.data, data);
            end
            default: begin
                $display("Unknown operation in entry %0d", index);
                $display("*** TEST FAILED ***");
                $fatal(1, "bad table entry");
            end
        endcase
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        store_req  = '0;
        load_req   = '0;
        irq_ack    = 1'b0;
        digital_in = '0;
        seed       = 99;
        gpo_model  = '0;
        pin_model  = '0;
        build_table();
        cycle_limit = table_q.size() * 16 + 200;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (3) @(negedge clk_i);  // internal reset leaves the two-flop synchronizer
        check_value("reset digital_o", 0, word_t'(digital_out));
        check_value("reset irq_o", 0, word_t'(irq));
        check_value("reset store_done_o", 0, word_t'(store_done));
        check_value("reset load_valid_o", 0, word_t'(load_valid));
        foreach (table_q[i]) begin
            run_entry(table_q[i], i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : io_board_tb

`default_nettype wire

//--- io_board.f
+incdir+common
common/board_pkg.sv
hdl/mmio_arbiter.sv
hdl/data_memory.sv
gpio/gpio_ports.sv
timer/mmio_timer.sv
hdl/interrupt_controller.sv
hdl/io_board.sv
verif/io_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module io_board_tb -f io_board.f \
    && ./obj_dir/Vio_board_tb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
